// ==== src.f ====
hdl/iir_pkg.sv
hdl/iir_regs.sv
hdl/iir_sample_buf.sv
hdl/iir_biquad.sv
hdl/iir_block_seq.sv
hdl/iir_top.sv
dv/iir_tb_sva.sv
dv/iir_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module iir_tb -f src.f -o iir_sim

./obj_dir/iir_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
   echo "simulation failed"
   exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi
echo "simulation passed"

// ==== dv/iir_tb.sv ====
`timescale 1ns/100ps

module iir_tb;
   import iir_pkg::*;

   localparam int N_SAMPLES = 32;
   localparam int CLK_NS    = 4;
   localparam int SEED      = 32'h43f8;
   // blocks run over all tests, each access spans two clocks
   localparam int BLOCKS      = 10;
   localparam int WATCHDOG_NS = BLOCKS * (3 * N_SAMPLES + 40) * 2 * CLK_NS * 4;

   logic        wb_clk_i = 1'b0;
   logic        wb_rst_i;
   logic [31:0] wb_adr_i;
   logic        wb_cyc_i;
   logic [31:0] wb_dat_i;
   logic [3:0]  wb_sel_i;
   logic        wb_stb_i;
   logic        wb_we_i;
   logic        wb_ack_o;
   logic        wb_err_o;
   logic [31:0] wb_dat_o;
   logic        int_o;

   sample_t   x_vals [N_SAMPLES];
   result_t   exp_y [N_SAMPLES];
   coef_set_t cs;
   logic      irq_on;
   string     cur_test;
   int        errors;
   int        checks;
   int        tests;
   int        test_err0;

   iir_top #(
      .N_SAMPLES (N_SAMPLES)
   ) UUT (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .wb_adr_i (wb_adr_i),
      .wb_cyc_i (wb_cyc_i),
      .wb_dat_i (wb_dat_i),
      .wb_sel_i (wb_sel_i),
      .wb_stb_i (wb_stb_i),
      .wb_we_i  (wb_we_i),
      .wb_ack_o (wb_ack_o),
      .wb_err_o (wb_err_o),
      .wb_dat_o (wb_dat_o),
      .int_o    (int_o)
   );

   always #(CLK_NS / 2) wb_clk_i = ~wb_clk_i;

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, the tests did not finish in time");
      $display("ERRORS FOUND");
      $finish;
   end

   task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         $display("ERR %s %s expected %08h actual %08h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_true(input bit cond, input string msg);
      checks++;
      assert (cond) else begin
         $display("%s: %s", cur_test, msg);
         errors++;
      end
   endtask

   function automatic logic [31:0] byte_adr(input logic [5:0] w);
      return {24'd0, w, 2'b00};
   endfunction

   // one classic cycle, driven and sampled on falling edges
   task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      int n;
      @(negedge wb_clk_i);
      wb_adr_i = adr;
      wb_dat_i = wdata;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      n = 0;
      do begin
         @(negedge wb_clk_i);
         n++;
      end while (!wb_ack_o && !wb_err_o && n < 8);
      check_true(wb_ack_o || wb_err_o, "no bus response within 8 clocks");
      rdata    = wb_dat_o;
      err      = wb_err_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic write_reg(input reg_addr_e r, input logic [31:0] d);
      logic [31:0] rdata;
      logic        err;
      bus_access(1'b1, byte_adr(r), d, rdata, err);
      check_true(!err, $sformatf("write to %s was rejected", r.name()));
   endtask

   task automatic write_rejected(input reg_addr_e r, input logic [31:0] d);
      logic [31:0] rdata;
      logic        err;
      bus_access(1'b1, byte_adr(r), d, rdata, err);
      check_true(err, $sformatf("write to %s during a block was accepted", r.name()));
   endtask

   task automatic read_reg(input reg_addr_e r, output logic [31:0] d);
      logic err;
      bus_access(1'b0, byte_adr(r), 32'd0, d, err);
      check_true(!err, $sformatf("read of %s was rejected", r.name()));
   endtask

   task automatic read_check(input reg_addr_e r, input logic [31:0] exp);
      logic [31:0] d;
      read_reg(r, d);
      check_val(r.name(), exp, d);
   endtask

   task automatic begin_test(input string name);
      cur_test  = name;
      test_err0 = errors;
   endtask

   task automatic end_test();
      tests++;
      $display("test %-12s finished, %0d errors", cur_test, errors - test_err0);
   endtask

   task automatic random_samples(input int len);
      for (int k = 0; k < len; k++) begin
         x_vals[k] = sample_t'($urandom);
      end
   endtask

   // upper half of each word is junk, the buffer keeps the low half
   task automatic load_samples(input int len);
      write_reg(X_ADDR, 32'd0);
      for (int k = 0; k < len; k++) begin
         write_reg(X_DATA, {16'($urandom), x_vals[k]});
      end
   endtask

   task automatic random_coefs();
      cs.b0 = coef_t'(int'($urandom_range(0, 8191)) - 4096);
      cs.b1 = coef_t'(int'($urandom_range(0, 8191)) - 4096);
      cs.b2 = coef_t'(int'($urandom_range(0, 8191)) - 4096);
      cs.a1 = coef_t'(int'($urandom_range(0, 4095)) - 2048);
      cs.a2 = coef_t'(int'($urandom_range(0, 4095)) - 2048);
   endtask

   task automatic load_coefs();
      write_reg(B0, 32'(cs.b0));
      write_reg(B1, 32'(cs.b1));
      write_reg(B2, 32'(cs.b2));
      write_reg(A1, 32'(cs.a1));
      write_reg(A2, 32'(cs.a2));
   endtask

   // direct form I, 48 bit wrap, shift, keep 32 bits
   task automatic filter_model(input int len);
      longint             acc;
      logic signed [47:0] acc48;
      logic signed [47:0] sh;
      sample_t            x1;
      sample_t            x2;
      result_t            y1;
      result_t            y2;
      x1 = '0;
      x2 = '0;
      y1 = '0;
      y2 = '0;
      for (int k = 0; k < len; k++) begin
         acc = longint'(cs.b0) * longint'(x_vals[k]) + longint'(cs.b1) * longint'(x1)
             + longint'(cs.b2) * longint'(x2) - longint'(cs.a1) * longint'(y1)
             - longint'(cs.a2) * longint'(y2);
         acc48    = acc[47:0];
         sh       = acc48 >>> COEF_FRAC;
         exp_y[k] = sh[31:0];
         x2 = x1;
         x1 = x_vals[k];
         y2 = y1;
         y1 = exp_y[k];
      end
   endtask

   task automatic wait_done();
      logic [31:0] st;
      logic        err;
      int          polls;
      polls = 0;
      do begin
         bus_access(1'b0, byte_adr(STATUS), 32'd0, st, err);
         polls++;
      end while (st[1:0] != 2'b10 && polls < N_SAMPLES + 8);
      check_true(st[1:0] == 2'b10, "block did not finish");
   endtask

   task automatic run_block(input int len);
      write_reg(STATUS, 32'h2);
      write_reg(LEN, len);
      write_reg(CTRL, {30'd0, irq_on, 1'b1});
      wait_done();
   endtask

   task automatic check_results(input int len);
      logic [31:0] d;
      for (int k = 0; k < len; k++) begin
         write_reg(Y_ADDR, k);
         read_reg(Y_DATA, d);
         check_val($sformatf("Y[%0d]", k), exp_y[k], d);
      end
   endtask

   task automatic test_regs();
      logic [31:0] d;
      logic        err;
      begin_test("regs");
      check_val("int_o", 32'd0, 32'(int_o));
      read_check(STATUS, 32'd0);
      read_check(CTRL, 32'd0);
      write_reg(LEN, 32'd20);
      read_check(LEN, 32'd20);
      // longer than the buffer clamps to its size
      write_reg(LEN, 32'd1000);
      read_check(LEN, N_SAMPLES);
      write_reg(B0, 32'h0000_4000);
      write_reg(B1, 32'h1234_8001);
      write_reg(A2, 32'hffff_f000);
      read_check(B0, 32'h0000_4000);
      read_check(B1, 32'hffff_8001);
      read_check(A2, 32'hffff_f000);
      write_reg(X_ADDR, 32'd7);
      read_check(X_ADDR, 32'd7);
      write_reg(Y_ADDR, 32'd3);
      read_check(Y_ADDR, 32'd3);
      write_reg(CTRL, 32'h2);
      read_check(CTRL, 32'h2);
      write_reg(CTRL, 32'h0);
      bus_access(1'b0, byte_adr(6'd12), 32'd0, d, err);
      check_true(err, "read of unmapped word 12 was not rejected");
      bus_access(1'b1, 32'h0000_0100, 32'd5, d, err);
      check_true(err, "write above the register window was not rejected");
      end_test();
   endtask

   task automatic test_identity();
      begin_test("identity");
      cs = '0;
      cs.b0 = 16'sd16384;
      load_coefs();
      random_samples(N_SAMPLES);
      load_samples(N_SAMPLES);
      for (int k = 0; k < N_SAMPLES; k++) begin
         exp_y[k] = {{16{x_vals[k][15]}}, x_vals[k]};
      end
      run_block(N_SAMPLES);
      check_results(N_SAMPLES);
      end_test();
   endtask

   task automatic test_random_blocks();
      int len;
      begin_test("random");
      for (int b = 0; b < 4; b++) begin
         len = $urandom_range(1, N_SAMPLES);
         random_coefs();
         load_coefs();
         random_samples(len);
         load_samples(len);
         filter_model(len);
         run_block(len);
         check_results(len);
      end
      end_test();
   endtask

   task automatic test_irq();
      begin_test("irq");
      irq_on = 1'b0;
      write_reg(CTRL, 32'h0);
      run_block(4);
      read_check(STATUS, 32'h2);
      check_val("int_o masked", 32'd0, 32'(int_o));
      write_reg(CTRL, 32'h2);
      check_val("int_o enabled", 32'd1, 32'(int_o));
      write_reg(STATUS, 32'h2);
      check_val("int_o cleared", 32'd0, 32'(int_o));
      read_check(STATUS, 32'h0);
      irq_on = 1'b1;
      run_block(4);
      check_val("int_o at done", 32'd1, 32'(int_o));
      write_reg(STATUS, 32'h2);
      check_val("int_o after clear", 32'd0, 32'(int_o));
      irq_on = 1'b0;
      write_reg(CTRL, 32'h0);
      end_test();
   endtask

   task automatic test_busy_lock();
      begin_test("busy_lock");
      random_coefs();
      load_coefs();
      random_samples(N_SAMPLES);
      load_samples(N_SAMPLES);
      filter_model(N_SAMPLES);
      // a stray write here would land on the last sample, read late in the block
      write_reg(X_ADDR, N_SAMPLES - 1);
      write_reg(STATUS, 32'h2);
      write_reg(LEN, N_SAMPLES);
      write_reg(CTRL, 32'h1);
      write_rejected(X_DATA, {16'd0, ~x_vals[N_SAMPLES-1]});
      write_rejected(B0, 32'(~cs.b0));
      write_rejected(LEN, 32'd1);
      write_reg(CTRL, 32'h1);
      // block ends LEN+3 clocks after its start
      // a restarted or queued block would still be busy at this read
      repeat (N_SAMPLES - 4) @(negedge wb_clk_i);
      read_check(STATUS, 32'h2);
      // a second block would set done again
      write_reg(STATUS, 32'h2);
      repeat (N_SAMPLES + 8) @(negedge wb_clk_i);
      read_check(STATUS, 32'h0);
      read_check(B0, 32'(cs.b0));
      read_check(LEN, N_SAMPLES);
      read_check(X_ADDR, N_SAMPLES - 1);
      check_results(N_SAMPLES);
      end_test();
   endtask

   task automatic test_full_block();
      begin_test("x_addr_full");
      write_reg(X_ADDR, 32'd0);
      for (int k = 0; k < 5; k++) begin
         write_reg(X_DATA, k);
      end
      read_check(X_ADDR, 32'd5);
      write_reg(X_ADDR, N_SAMPLES - 2);
      for (int k = 0; k < 3; k++) begin
         write_reg(X_DATA, k);
      end
      // wraps past the end of the buffer
      read_check(X_ADDR, 32'd1);
      random_coefs();
      load_coefs();
      random_samples(N_SAMPLES);
      load_samples(N_SAMPLES);
      filter_model(N_SAMPLES);
      run_block(N_SAMPLES);
      check_results(N_SAMPLES);
      end_test();
   endtask

   initial begin
      void'($urandom(SEED));
      errors   = 0;
      checks   = 0;
      tests    = 0;
      irq_on   = 1'b0;
      wb_rst_i = 1'b1;
      wb_adr_i = 32'd0;
      wb_cyc_i = 1'b0;
      wb_dat_i = 32'd0;
      wb_sel_i = 4'hf;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
      repeat (3) @(negedge wb_clk_i);
      wb_rst_i = 1'b0;

      test_regs();
      test_identity();
      test_random_blocks();
      test_irq();
      test_busy_lock();
      test_full_block();

      $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests, checks, errors, UUT.u_sva.fail_cnt);
      if (errors == 0 && UUT.u_sva.fail_cnt == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// ==== dv/iir_tb_sva.sv ====
`timescale 1ns/100ps

module iir_tb_sva (
   input logic clk_i,
   input logic rst_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i,
   input logic err_i,
   input logic int_i,
   input logic block_done_i
);

   // read by the testbench summary
   int fail_cnt = 0;

   // bus and interrupt quiet right after a reset edge
   reset_quiet: assert property (@(posedge clk_i) rst_i |=> !ack_i && !err_i && !int_i)
      else begin
         $error("bus or interrupt output high after reset");
         fail_cnt++;
      end

   ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_i && err_i))
      else begin
         $error("ack and err high together");
         fail_cnt++;
      end

   // every request gets exactly one response on the next clock
   resp_next: assert property (@(posedge clk_i) disable iff (rst_i)
         (cyc_i && stb_i && !ack_i && !err_i) |=> (ack_i ^ err_i))
      else begin
         $error("request without a single response one clock later");
         fail_cnt++;
      end

   resp_single: assert property (@(posedge clk_i) disable iff (rst_i)
         (ack_i || err_i) |=> !(ack_i || err_i))
      else begin
         $error("response held longer than one clock");
         fail_cnt++;
      end

   // interrupt rises at block end or on a register write
   int_rise: assert property (@(posedge clk_i) disable iff (rst_i)
         $rose(int_i) |-> (ack_i || $past(block_done_i)))
      else begin
         $error("interrupt rose without block end or register write");
         fail_cnt++;
      end

   // only a register write takes it down
   int_fall: assert property (@(posedge clk_i) disable iff (rst_i)
         $fell(int_i) |-> ack_i)
      else begin
         $error("interrupt fell without a register write");
         fail_cnt++;
      end

endmodule

bind iir_top iir_tb_sva u_sva (
   .clk_i        (wb_clk_i),
   .rst_i        (wb_rst_i),
   .cyc_i        (wb_cyc_i),
   .stb_i        (wb_stb_i),
   .ack_i        (wb_ack_o),
   .err_i        (wb_err_o),
   .int_i        (int_o),
   .block_done_i (block_done)
);

// ==== hdl/iir_top.sv ====
`timescale 1ns/100ps

module iir_top #(
   parameter int N_SAMPLES = 32
) (
   input  logic        wb_clk_i,
   input  logic        wb_rst_i,
   input  logic [31:0] wb_adr_i,
   input  logic        wb_cyc_i,
   input  logic [31:0] wb_dat_i,
   // byte lanes not supported, every write is a full word
   input  logic [3:0]  wb_sel_i,
   input  logic        wb_stb_i,
   input  logic        wb_we_i,
   output logic        wb_ack_o,
   output logic        wb_err_o,
   output logic [31:0] wb_dat_o,
   output logic        int_o
);
   import iir_pkg::*;

   localparam int IW = $clog2(N_SAMPLES);
   localparam int LW = IW + 1;

   coef_set_t     coef;
   logic [LW-1:0] len;
   logic          start;
   logic          busy;
   logic          block_done;
   buf_wr_t       x_wr;
   buf_wr_t       y_wr;
   logic [IW-1:0] x_rd_addr;
   logic [IW-1:0] y_rd_addr;
   sample_t       x_rd_data;
   result_t       y_rd_data;
   logic          core_valid_in;
   logic          core_clear;
   result_t       core_result;
   logic          core_valid_out;

   iir_regs #(
      .N_SAMPLES (N_SAMPLES)
   ) u_regs (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .wb_adr_i     (wb_adr_i),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_dat_i     (wb_dat_i),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .wb_err_o     (wb_err_o),
      .int_o        (int_o),
      .coef_o       (coef),
      .len_o        (len),
      .start_o      (start),
      .x_wr_o       (x_wr),
      .y_addr_o     (y_rd_addr),
      .y_data_i     (y_rd_data),
      .busy_i       (busy),
      .block_done_i (block_done)
   );

   // input samples
   iir_sample_buf #(
      .N_SAMPLES (N_SAMPLES),
      .entry_t   (sample_t)
   ) u_xbuf (
      .wb_clk_i  (wb_clk_i),
      .wr_i      (x_wr),
      .rd_addr_i (x_rd_addr),
      .rd_data_o (x_rd_data)
   );

   // filter results
   iir_sample_buf #(
      .N_SAMPLES (N_SAMPLES),
      .entry_t   (result_t)
   ) u_ybuf (
      .wb_clk_i  (wb_clk_i),
      .wr_i      (y_wr),
      .rd_addr_i (y_rd_addr),
      .rd_data_o (y_rd_data)
   );

   iir_block_seq #(
      .N_SAMPLES (N_SAMPLES)
   ) u_seq (
      .wb_clk_i      (wb_clk_i),
      .wb_rst_i      (wb_rst_i),
      .start_i       (start),
      .len_i         (len),
      .x_rd_addr_o   (x_rd_addr),
      .core_valid_o  (core_valid_in),
      .core_clear_o  (core_clear),
      .core_result_i (core_result),
      .core_valid_i  (core_valid_out),
      .y_wr_o        (y_wr),
      .busy_o        (busy),
      .block_done_o  (block_done)
   );

   iir_biquad u_core (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .coef_i   (coef),
      .clear_i  (core_clear),
      .sample_i (x_rd_data),
      .valid_i  (core_valid_in),
      .result_o (core_result),
      .valid_o  (core_valid_out)
   );

endmodule

// ==== hdl/iir_block_seq.sv ====
`timescale 1ns/100ps

module iir_block_seq #(
   parameter int N_SAMPLES = 32
) (
   input  logic                          wb_clk_i,
   input  logic                          wb_rst_i,
   input  logic                          start_i,
   input  logic [$clog2(N_SAMPLES):0]    len_i,
   output logic [$clog2(N_SAMPLES)-1:0]  x_rd_addr_o,
   output logic                          core_valid_o,
   output logic                          core_clear_o,
   input  iir_pkg::result_t              core_result_i,
   input  logic                          core_valid_i,
   output iir_pkg::buf_wr_t              y_wr_o,
   output logic                          busy_o,
   output logic                          block_done_o
);
   import iir_pkg::*;

   localparam int IW = $clog2(N_SAMPLES);
   localparam int LW = IW + 1;

   logic          rd_active;
   logic [IW-1:0] y_idx;
   logic [LW-1:0] len_q;
   logic          rd_last;
   logic          y_last;
   logic          empty_q;

   assign rd_last = ({1'b0, x_rd_addr_o} == len_q - 1'b1);
   assign y_last  = ({1'b0, y_idx} == len_q - 1'b1);

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         busy_o       <= 1'b0;
         rd_active    <= 1'b0;
         core_valid_o <= 1'b0;
         core_clear_o <= 1'b0;
         empty_q      <= 1'b0;
         x_rd_addr_o  <= '0;
         y_idx        <= '0;
         len_q        <= '0;
      end else begin
         core_clear_o <= 1'b0;
         empty_q      <= 1'b0;
         // matches the one cycle buffer read
         core_valid_o <= rd_active;

         if (start_i && !busy_o) begin
            if (len_i == '0) begin
               // nothing to filter, report done right away
               empty_q <= 1'b1;
            end else begin
               busy_o       <= 1'b1;
               rd_active    <= 1'b1;
               core_clear_o <= 1'b1;
               x_rd_addr_o  <= '0;
               y_idx        <= '0;
               len_q        <= len_i;
            end
         end

         // read side, one address per clock
         if (rd_active) begin
            if (rd_last) begin
               rd_active <= 1'b0;
            end else begin
               x_rd_addr_o <= x_rd_addr_o + 1'b1;
            end
         end

         // write side follows the core output
         if (core_valid_i) begin
            y_idx <= y_idx + 1'b1;
            if (y_last) begin
               busy_o <= 1'b0;
            end
         end
      end
   end

   assign y_wr_o.en   = core_valid_i;
   assign y_wr_o.addr = {{(BUF_AW-IW){1'b0}}, y_idx};
   assign y_wr_o.data = core_result_i;

   // pulses with the final result write
   assign block_done_o = (core_valid_i & y_last) | empty_q;

endmodule

// ==== hdl/iir_biquad.sv ====
`timescale 1ns/100ps

module iir_biquad (
   input  logic               wb_clk_i,
   input  logic               wb_rst_i,
   input  iir_pkg::coef_set_t coef_i,
   input  logic               clear_i,
   input  iir_pkg::sample_t   sample_i,
   input  logic               valid_i,
   output iir_pkg::result_t   result_o,
   output logic               valid_o
);
   import iir_pkg::*;

   localparam int ACC_W = 48;

   // direct form I history
   sample_t x1;
   sample_t x2;
   result_t y1;
   result_t y2;

   logic signed [ACC_W-1:0] p_b0;
   logic signed [ACC_W-1:0] p_b1;
   logic signed [ACC_W-1:0] p_b2;
   logic signed [ACC_W-1:0] p_a1;
   logic signed [ACC_W-1:0] p_a2;
   logic signed [ACC_W-1:0] acc;
   logic signed [ACC_W-1:0] acc_sh;
   result_t                 y_new;

   always_comb begin
      // all products sign extended to the accumulator width
      p_b0 = ACC_W'(coef_i.b0) * ACC_W'(sample_i);
      p_b1 = ACC_W'(coef_i.b1) * ACC_W'(x1);
      p_b2 = ACC_W'(coef_i.b2) * ACC_W'(x2);
      p_a1 = ACC_W'(coef_i.a1) * ACC_W'(y1);
      p_a2 = ACC_W'(coef_i.a2) * ACC_W'(y2);

      acc    = p_b0 + p_b1 + p_b2 - p_a1 - p_a2;
      acc_sh = acc >>> COEF_FRAC;

      // no saturation, the result wraps
      y_new = acc_sh[31:0];
   end

   // history moves only with a valid sample
   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i || clear_i) begin
         x1 <= '0;
         x2 <= '0;
         y1 <= '0;
         y2 <= '0;
      end else if (valid_i) begin
         x1 <= sample_i;
         x2 <= x1;
         y1 <= y_new;
         y2 <= y1;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (valid_i) begin
         result_o <= y_new;
      end
   end

endmodule

// ==== hdl/iir_sample_buf.sv ====
`timescale 1ns/100ps

module iir_sample_buf #(
   parameter int  N_SAMPLES = 32,
   parameter type entry_t   = iir_pkg::sample_t
) (
   input  logic                          wb_clk_i,
   input  iir_pkg::buf_wr_t              wr_i,
   input  logic [$clog2(N_SAMPLES)-1:0]  rd_addr_i,
   output entry_t                        rd_data_o
);

   localparam int IW = $clog2(N_SAMPLES);
   localparam int EW = $bits(entry_t);

   entry_t        mem [N_SAMPLES];
   logic [IW-1:0] wr_addr;
   entry_t        wr_data;

   // index within the buffer, upper address bits are ignored
   assign wr_addr = wr_i.addr[IW-1:0];

   // samples keep only the low half of the bus word
   assign wr_data = entry_t'(wr_i.data[EW-1:0]);

   always_ff @(posedge wb_clk_i) begin
      if (wr_i.en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // one cycle read latency, old data on a same-address write
   always_ff @(posedge wb_clk_i) begin
      rd_data_o <= mem[rd_addr_i];
   end

endmodule

// ==== hdl/iir_regs.sv ====
`timescale 1ns/100ps

module iir_regs #(
   parameter int N_SAMPLES = 32
) (
   input  logic                          wb_clk_i,
   input  logic                          wb_rst_i,
   input  logic [31:0]                   wb_adr_i,
   input  logic                          wb_cyc_i,
   input  logic                          wb_stb_i,
   input  logic                          wb_we_i,
   input  logic [31:0]                   wb_dat_i,
   output logic [31:0]                   wb_dat_o,
   output logic                          wb_ack_o,
   output logic                          wb_err_o,
   output logic                          int_o,
   output iir_pkg::coef_set_t            coef_o,
   output logic [$clog2(N_SAMPLES):0]    len_o,
   output logic                          start_o,
   output iir_pkg::buf_wr_t              x_wr_o,
   output logic [$clog2(N_SAMPLES)-1:0]  y_addr_o,
   input  iir_pkg::result_t              y_data_i,
   input  logic                          busy_i,
   input  logic                          block_done_i
);
   import iir_pkg::*;

   localparam int IW = $clog2(N_SAMPLES);
   localparam int LW = IW + 1;

   reg_addr_e     word;
   logic          req;
   logic          mapped;
   logic          blocked;
   logic          accept;
   logic          wr_ok;
   logic          irq_en;
   logic          done;
   logic [IW-1:0] x_addr;
   logic [31:0]   rd_data;

   function automatic logic [31:0] sext(input coef_t c);
      return {{16{c[15]}}, c};
   endfunction

   assign word = reg_addr_e'(wb_adr_i[7:2]);

   // new request only while no response is on the bus
   assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
   assign mapped = (wb_adr_i[31:8] == '0) && (word <= Y_DATA);

   // block data and coefficients are locked during a run
   assign blocked = busy_i & wb_we_i &
                    ((word == LEN) || (word == X_DATA) || ((word >= B0) && (word <= A2)));

   assign accept = req & mapped & ~blocked;
   assign wr_ok  = accept & wb_we_i;

   always_comb begin
      case (word)
         CTRL:    rd_data = {30'd0, irq_en, 1'b0};
         STATUS:  rd_data = {30'd0, done, busy_i};
         LEN:     rd_data = 32'(len_o);
         B0:      rd_data = sext(coef_o.b0);
         B1:      rd_data = sext(coef_o.b1);
         B2:      rd_data = sext(coef_o.b2);
         A1:      rd_data = sext(coef_o.a1);
         A2:      rd_data = sext(coef_o.a2);
         X_ADDR:  rd_data = 32'(x_addr);
         Y_ADDR:  rd_data = 32'(y_addr_o);
         Y_DATA:  rd_data = y_data_i;
         default: rd_data = '0;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (wb_rst_i) begin
         wb_ack_o  <= 1'b0;
         wb_err_o  <= 1'b0;
         start_o   <= 1'b0;
         irq_en    <= 1'b0;
         done      <= 1'b0;
         len_o     <= '0;
         coef_o    <= '0;
         x_addr    <= '0;
         y_addr_o  <= '0;
         x_wr_o.en <= 1'b0;
      end else begin
         wb_ack_o <= accept;
         wb_err_o <= req & ~accept;
         // start is dropped while a block is running
         start_o  <= wr_ok & (word == CTRL) & wb_dat_i[0] & ~busy_i;

         x_wr_o.en   <= wr_ok & (word == X_DATA);
         x_wr_o.addr <= {{(BUF_AW-IW){1'b0}}, x_addr};
         x_wr_o.data <= wb_dat_i;

         // end of block wins over a clear in the same cycle
         if (block_done_i) begin
            done <= 1'b1;
         end else if (wr_ok && (word == STATUS) && wb_dat_i[1]) begin
            done <= 1'b0;
         end

         if (wr_ok) begin
            case (word)
               CTRL:   irq_en <= wb_dat_i[1];
               LEN: begin
                  if (wb_dat_i > 32'(N_SAMPLES)) begin
                     len_o <= LW'(N_SAMPLES);
                  end else begin
                     len_o <= wb_dat_i[LW-1:0];
                  end
               end
               B0:     coef_o.b0 <= wb_dat_i[15:0];
               B1:     coef_o.b1 <= wb_dat_i[15:0];
               B2:     coef_o.b2 <= wb_dat_i[15:0];
               A1:     coef_o.a1 <= wb_dat_i[15:0];
               A2:     coef_o.a2 <= wb_dat_i[15:0];
               X_ADDR: x_addr <= wb_dat_i[IW-1:0];
               // wraps at the end of the buffer
               X_DATA: x_addr <= x_addr + 1'b1;
               Y_ADDR: y_addr_o <= wb_dat_i[IW-1:0];
               default: ;
            endcase
         end
      end
   end

   // read data sampled on the accepting edge
   always_ff @(posedge wb_clk_i) begin
      if (req) begin
         wb_dat_o <= rd_data;
      end
   end

   assign int_o = done & irq_en;

endmodule

// ==== hdl/iir_pkg.sv ====
package iir_pkg;

   // input samples and coefficients are 16 bit signed
   typedef logic signed [15:0] sample_t;

   // Q1.14 coefficient
   typedef logic signed [15:0] coef_t;

   // filter output, wraps in 32 bits
   typedef logic signed [31:0] result_t;

   // fraction bits dropped after accumulation
   localparam int COEF_FRAC = 14;

   // width of the buffer write address field
   localparam int BUF_AW = 16;

   // one biquad section
   typedef struct packed {
      coef_t b0;
      coef_t b1;
      coef_t b2;
      coef_t a1;
      coef_t a2;
   } coef_set_t;

   // write request into a sample buffer
   typedef struct packed {
      logic              en;
      logic [BUF_AW-1:0] addr;
      logic [31:0]       data;
   } buf_wr_t;

   // word addresses, byte address bits [7:2]
   typedef enum logic [5:0] {
      CTRL   = 6'd0,
      STATUS = 6'd1,
      LEN    = 6'd2,
      B0     = 6'd3,
      B1     = 6'd4,
      B2     = 6'd5,
      A1     = 6'd6,
      A2     = 6'd7,
      X_ADDR = 6'd8,
      X_DATA = 6'd9,
      Y_ADDR = 6'd10,
      Y_DATA = 6'd11
   } reg_addr_e;

endpackage
